/* list.f */
verilog/dm_pkg.sv
verilog/dm_dmi_regs.sv
verilog/dm_hart_ctl.sv
verilog/dm_hart_select.sv
verilog/dm_top.sv
verif/dm_tb.sv

/* run.sh */
#!/bin/sh
# build with Verilator, run, and pass only when the testbench prints its pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f list.f --top-module dm_tb -o dm_sim &&
./obj_dir/dm_sim | tee /dev/stderr | grep -x "RESULT: PASS" > /dev/null &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

/* verif/dm_tb.sv */
// hart model halts a cycle after halt_req_o, acks a resume a cycle late, rf writes land 1 ns in
`timescale 1ns/1ps

module dm_tb;
    import dm_pkg::*;

    localparam int max_entries = 40;
    localparam int side_none   = 0;
    localparam int side_halt   = 1; // halt_req_o vector
    localparam int side_resume = 2; // resume_req_o vector
    localparam int side_acked  = 3;
    localparam int side_reg    = 4; // hart 2 register 5
    localparam int side_rfwr   = 5;

    logic       clk_i = 1'b0;
    logic       rstn_i;
    logic       req_valid;
    logic       req_ready;
    dmi_addr_t  req_addr;
    dmi_data_t  req_data;
    dmi_op_t    req_op;
    logic       resp_valid;
    logic       resp_ready;
    dmi_data_t  resp_data;
    dmi_op_t    resp_op;
    hart_vec_t  halt_req;
    hart_vec_t  resume_req;
    hart_vec_t  rf_we;
    hart_vec_t  resume_ack = '0;
    hart_vec_t  halted = '0;
    hart_vec_t  running = '1;
    hart_vec_t  havereset = '0;
    regno_t     rf_addr [num_harts];
    dmi_data_t  rf_wdata [num_harts];
    dmi_data_t  rf_rdata [num_harts];
    dmi_data_t  regs [num_harts][32];

    dmi_op_t    t_op [max_entries];
    dmi_addr_t  t_addr [max_entries];
    dmi_data_t  t_wdata [max_entries];
    dmi_data_t  t_exp [max_entries];
    dmi_data_t  t_mask [max_entries];
    int         t_grp [max_entries];
    int         t_side [max_entries];
    dmi_data_t  t_sval [max_entries];
    string      grp_name [7];

    int          n_entries = 0;
    int          pass_cnt = 0;
    int          fail_cnt = 0;
    int          cycles = 0;
    int          limit = 1000;
    int          wr_cnt = 0;   // rf writes on hart 2
    int          other_wr = 0; // rf writes on any other hart
    int          ack_cnt = 0;  // resume acks from hart 2
    logic        hr_done = 1'b0;
    logic [31:0] rng = 32'ha2f6;

    always #5 clk_i = ~clk_i;

    dm_top i_dm_top (
        .clk_i, .rstn_i,
        .req_valid_i  (req_valid),
        .req_ready_o  (req_ready),
        .req_addr_i   (req_addr),
        .req_data_i   (req_data),
        .req_op_i     (req_op),
        .resp_valid_o (resp_valid),
        .resp_ready_i (resp_ready),
        .resp_data_o  (resp_data),
        .resp_op_o    (resp_op),
        .halt_req_o   (halt_req),
        .resume_req_o (resume_req),
        .resume_ack_i (resume_ack),
        .halted_i     (halted),
        .running_i    (running),
        .havereset_i  (havereset),
        .rf_we_o      (rf_we),
        .rf_addr_o    (rf_addr),
        .rf_wdata_o   (rf_wdata),
        .rf_rdata_i   (rf_rdata)
    );

    always_comb begin
        for (int h = 0; h < num_harts; h++) begin
            rf_rdata[h] = regs[h][rf_addr[h]];
        end
    end

    // hart model, updated 1 ns after each edge
    always @(posedge clk_i) begin
        #1;
        if (!rstn_i) begin
            for (int h = 0; h < num_harts; h++) begin
                for (int i = 0; i < 32; i++) begin
                    regs[h][i] = i * 32'h01010101 + h;
                end
            end
        end else begin
            havereset = hr_done ? '0 : hart_vec_t'(4'b0010); // one pulse on hart 1
            hr_done = 1'b1;
            for (int h = 0; h < num_harts; h++) begin
                if (rf_we[h]) begin
                    regs[h][rf_addr[h]] = rf_wdata[h];
                    if (h == 2) wr_cnt++;
                    else other_wr++;
                end
                if (resume_req[h] && !resume_ack[h]) begin
                    resume_ack[h] = 1'b1;
                    halted[h] = 1'b0; // the ack also ends the halt
                    if (h == 2) ack_cnt++;
                end else begin
                    resume_ack[h] = 1'b0;
                    if (halt_req[h]) halted[h] = 1'b1;
                end
            end
            running = ~halted;
        end
    end

    always @(posedge clk_i) begin
        cycles++;
        if (cycles > limit) begin
            $display("timeout: the run hung after %0d cycles", cycles);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [31:0] next_random();
        rng = xorshift32(rng);
        return rng;
    endfunction

    task automatic add_entry(input int grp, input dmi_op_t op, input dmi_addr_t addr,
                             input dmi_data_t wdata, input dmi_data_t exp,
                             input dmi_data_t mask, input int side, input dmi_data_t sval);
        t_grp[n_entries]   = grp;
        t_op[n_entries]    = op;
        t_addr[n_entries]  = addr;
        t_wdata[n_entries] = wdata;
        t_exp[n_entries]   = exp;
        t_mask[n_entries]  = mask;
        t_side[n_entries]  = side;
        t_sval[n_entries]  = sval;
        n_entries++;
    endtask

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED t=%0t %s got 0x%08h expected 0x%08h", $time, name, got, exp);
            fail_cnt++;
        end else begin
            pass_cnt++;
        end
    endtask

    task automatic dmi_xfer(input dmi_op_t op, input dmi_addr_t addr, input dmi_data_t wdata,
                            output dmi_data_t rdata, output dmi_op_t rop);
        @(posedge clk_i);
        #1;
        while (!req_ready) begin
            @(posedge clk_i);
            #1;
        end
        req_valid = 1'b1;
        req_op    = op;
        req_addr  = addr;
        req_data  = wdata;
        @(posedge clk_i);
        #1;
        req_valid = 1'b0; // accepted at that edge
        req_op    = dmi_op_nop;
        while (!resp_valid) begin
            @(posedge clk_i);
            #1;
        end
        @(negedge clk_i);
        rdata = resp_data;
        rop   = resp_op;
    endtask

    task automatic side_check(input int side, input dmi_data_t sval);
        case (side)
            side_halt:   compare("halt_req_o", 32'(halt_req), sval);
            side_resume: compare("resume_req_o", 32'(resume_req), sval);
            side_acked: begin
                compare("resume_req_o", 32'(resume_req), 32'h0);
                compare("resume_ack_i pulses", 32'(ack_cnt), sval);
            end
            side_reg:    compare("hart 2 x5", regs[2][5], sval);
            side_rfwr: begin
                compare("hart 2 rf_we_o count", 32'(wr_cnt), sval);
                compare("other rf_we_o count", 32'(other_wr), 32'h0);
            end
            default: ;
        endcase
    endtask

    initial begin : stimulus
        dmi_data_t rdata;
        dmi_op_t   rop;
        dmi_data_t r1;
        dmi_data_t r2;
        dmi_data_t r3;
        int        grp_fail;
        rstn_i     = 1'b0;
        req_valid  = 1'b0;
        req_addr   = '0;
        req_data   = '0;
        req_op     = dmi_op_nop;
        resp_ready = 1'b1;
        grp_name   = '{"", "data words", "halt", "resume", "register access",
                       "command errors", "nonexistent hart"};
        r1 = next_random();
        r2 = next_random();
        r3 = next_random();
        add_entry(1, dmi_op_rd, addr_data0, 32'h0, 32'h0, '1, side_none, 32'h0);
        add_entry(1, dmi_op_rd, addr_data1, 32'h0, 32'h0, '1, side_none, 32'h0);
        add_entry(1, dmi_op_rd, addr_abstractcs, 32'h0, 32'h2, 32'h70f, side_none, 32'h0);
        add_entry(1, dmi_op_wr, addr_data0, r1, 32'h0, 32'h0, side_none, 32'h0);
        add_entry(1, dmi_op_wr, addr_data1, r2, 32'h0, 32'h0, side_none, 32'h0);
        add_entry(1, dmi_op_rd, addr_data0, 32'h0, r1, '1, side_none, 32'h0);
        add_entry(1, dmi_op_rd, addr_data1, 32'h0, r2, '1, side_none, 32'h0);
        add_entry(2, dmi_op_wr, addr_dmcontrol, 32'h8002_0001, 32'h0, 32'h0, side_halt, 32'h4);
        // dmstatus low bits: version 3, authenticated
        add_entry(2, dmi_op_rd, addr_dmstatus, 32'h0, 32'h383, 32'hf8f, side_none, 32'h0);
        add_entry(3, dmi_op_wr, addr_dmcontrol, 32'h4002_0001, 32'h0, 32'h0, side_resume, 32'h4);
        add_entry(3, dmi_op_rd, addr_dmstatus, 32'h0, 32'h3_0c83, 32'h3_0f8f, side_acked, 32'h1);
        add_entry(3, dmi_op_wr, addr_dmcontrol, 32'h0001_0001, 32'h0, 32'h0, side_none, 32'h0);
        add_entry(3, dmi_op_rd, addr_dmstatus, 32'h0, 32'hc_0000, 32'hc_0000, side_none, 32'h0);
        add_entry(3, dmi_op_wr, addr_dmcontrol, 32'h1001_0001, 32'h0, 32'h0, side_none, 32'h0);
        add_entry(3, dmi_op_rd, addr_dmstatus, 32'h0, 32'h0, 32'hc_0000, side_none, 32'h0);
        add_entry(4, dmi_op_wr, addr_dmcontrol, 32'h8002_0001, 32'h0, 32'h0, side_halt, 32'h4);
        add_entry(4, dmi_op_wr, addr_data0, r3, 32'h0, 32'h0, side_none, 32'h0);
        add_entry(4, dmi_op_wr, addr_command, 32'h0023_1005, 32'h0, 32'h0, side_reg, r3);
        add_entry(4, dmi_op_wr, addr_command, 32'h0022_1003, 32'h0, 32'h0, side_none, 32'h0);
        add_entry(4, dmi_op_rd, addr_data0, 32'h0, 3 * 32'h01010101 + 2, '1, side_rfwr, 32'h1);
        // running hart 0 first, then hart 2 again while cmderr is still set
        add_entry(5, dmi_op_wr, addr_dmcontrol, 32'h0000_0001, 32'h0, 32'h0, side_none, 32'h0);
        add_entry(5, dmi_op_wr, addr_command, 32'h0023_1005, 32'h0, 32'h0, side_none, 32'h0);
        add_entry(5, dmi_op_rd, addr_abstractcs, 32'h0, 32'h402, 32'h70f, side_none, 32'h0);
        add_entry(5, dmi_op_wr, addr_dmcontrol, 32'h8002_0001, 32'h0, 32'h0, side_none, 32'h0);
        add_entry(5, dmi_op_wr, addr_command, 32'h0023_1007, 32'h0, 32'h0, side_rfwr, 32'h1);
        add_entry(5, dmi_op_wr, addr_abstractcs, 32'h700, 32'h0, 32'h0, side_none, 32'h0);
        add_entry(5, dmi_op_rd, addr_abstractcs, 32'h0, 32'h002, 32'h70f, side_none, 32'h0);
        add_entry(5, dmi_op_wr, addr_command, 32'h0033_1005, 32'h0, 32'h0, side_none, 32'h0);
        add_entry(5, dmi_op_rd, addr_abstractcs, 32'h0, 32'h202, 32'h70f, side_none, 32'h0);
        // hart 2 keeps its halt request while hartsel points past the last hart
        add_entry(6, dmi_op_wr, addr_dmcontrol, 32'h0006_0001, 32'h0, 32'h0, side_halt, 32'h4);
        add_entry(6, dmi_op_rd, addr_dmstatus, 32'h0, 32'hc000, 32'hf_cf00, side_none, 32'h0);
        add_entry(6, dmi_op_wr, addr_dmcontrol, 32'h8006_0001, 32'h0, 32'h0, side_halt, 32'h4);
        limit = n_entries * 30 + 100;
        repeat (5) @(posedge clk_i);
        #1;
        rstn_i = 1'b1;
        grp_fail = 0;
        for (int i = 0; i < n_entries; i++) begin
            dmi_xfer(t_op[i], t_addr[i], t_wdata[i], rdata, rop);
            compare($sformatf("resp_op_o #%0d", i), 32'(rop), 32'(dmi_resp_ok));
            compare($sformatf("resp_data_o #%0d", i), rdata & t_mask[i], t_exp[i] & t_mask[i]);
            side_check(t_side[i], t_sval[i]);
            if (i == n_entries - 1 || t_grp[i + 1] != t_grp[i]) begin
                $display("behavior %0d %s: %s (%0d errors)", t_grp[i], grp_name[t_grp[i]],
                         (fail_cnt == grp_fail) ? "ok" : "errors", fail_cnt - grp_fail);
                grp_fail = fail_cnt;
            end
        end
        $display("checks passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* verilog/dm_dmi_regs.sv */
// one DMI request in flight; command reads return 0 and abstract commands never report busy
`timescale 1ns/1ps

module dm_dmi_regs (
    input  logic                clk_i,
    input  logic                rstn_i,
    input  logic                req_valid_i,
    output logic                req_ready_o,
    input  dm_pkg::dmi_addr_t   req_addr_i,
    input  dm_pkg::dmi_data_t   req_data_i,
    input  dm_pkg::dmi_op_t     req_op_i,
    output logic                resp_valid_o,
    input  logic                resp_ready_i,
    output dm_pkg::dmi_data_t   resp_data_o,
    output dm_pkg::dmi_op_t     resp_op_o,
    output dm_pkg::hart_vec_t   ctl_wr_o,
    output dm_pkg::dmi_data_t   ctl_data_o,
    output dm_pkg::hartsel_t    hartsel_o,
    input  logic                sel_halted_i,
    input  logic                sel_running_i,
    input  logic                sel_resumeack_i,
    input  logic                sel_havereset_i,
    input  logic                sel_nonexistent_i,
    output logic                rf_we_o,
    output dm_pkg::regno_t      rf_addr_o,
    output dm_pkg::dmi_data_t   rf_wdata_o,
    input  dm_pkg::dmi_data_t   rf_rdata_i
);
    import dm_pkg::*;

    dm_state_t  state_q;
    dmi_addr_t  addr_q;
    dmi_op_t    op_q;
    dmi_data_t  dmctl_q;
    dmi_data_t  data0_q;
    dmi_data_t  data1_q;
    cmderr_t    cmderr_q;
    logic       cmd_write_q;
    regno_t     regno_q;

    logic       accept;
    logic       wr_acc;
    logic       dmc_wr;
    logic       cmd_wr;
    logic       cmd_ok;
    logic       start_access;
    logic [dmc_hartsello_hi:dmc_hartsello_lo] wr_hartsel;
    logic [cmd_regno_hi:0] cmd_regno;
    dmi_data_t  dmctl_wdata;
    dmi_data_t  status_word;
    dmi_data_t  acs_word;
    dmi_data_t  rdata;

    assign req_ready_o  = (state_q == dm_idle);
    assign resp_valid_o = (state_q == dm_resp);
    assign resp_op_o    = dmi_resp_ok;
    assign resp_data_o  = (resp_valid_o && op_q == dmi_op_rd) ? rdata : '0;

    assign accept = req_valid_i && req_ready_o;
    assign wr_acc = accept && (req_op_i == dmi_op_wr);
    assign dmc_wr = wr_acc && (req_addr_i == addr_dmcontrol);
    assign cmd_wr = wr_acc && (req_addr_i == addr_command);

    assign wr_hartsel = req_data_i[dmc_hartsello_hi:dmc_hartsello_lo];
    assign hartsel_o  = hartsel_t'(dmctl_q[dmc_hartsello_hi:dmc_hartsello_lo]);
    assign ctl_data_o = req_data_i;

    always_comb begin
        for (int h = 0; h < num_harts; h++) begin
            ctl_wr_o[h] = dmc_wr && (wr_hartsel == h); // no bit for a missing hart
        end
    end

    // only haltreq, hartsello and dmactive read back
    always_comb begin
        dmctl_wdata = '0;
        dmctl_wdata[dmc_haltreq] = req_data_i[dmc_haltreq];
        dmctl_wdata[dmc_hartsello_hi:dmc_hartsello_lo] = wr_hartsel;
        dmctl_wdata[dmc_dmactive] = req_data_i[dmc_dmactive];
    end

    assign cmd_regno = req_data_i[cmd_regno_hi:0];
    assign cmd_ok = (req_data_i[cmd_cmdtype_hi:cmd_cmdtype_lo] == cmdtype_access_reg)
                 && (req_data_i[cmd_aarsize_hi:cmd_aarsize_lo] == aarsize_32)
                 && (cmd_regno >= regno_gpr_first) && (cmd_regno <= regno_gpr_last);
    assign start_access = cmd_wr && (cmderr_q == cmderr_none) && sel_halted_i
                       && cmd_ok && req_data_i[cmd_transfer];

    // register file strobe lives for the single access cycle
    assign rf_we_o    = (state_q == dm_access) && cmd_write_q;
    assign rf_addr_o  = regno_q;
    assign rf_wdata_o = data0_q;

    always_comb begin
        status_word = '0;
        status_word[dms_version_hi:0]      = dms_version;
        status_word[dms_authenticated]     = 1'b1;
        status_word[dms_halted +: 2]       = {2{sel_halted_i}};
        status_word[dms_running +: 2]      = {2{sel_running_i}};
        status_word[dms_nonexistent +: 2]  = {2{sel_nonexistent_i}};
        status_word[dms_resumeack +: 2]    = {2{sel_resumeack_i}};
        status_word[dms_havereset +: 2]    = {2{sel_havereset_i}};
        acs_word = '0;
        acs_word[acs_datacount_hi:0]           = acs_datacount;
        acs_word[acs_cmderr_hi:acs_cmderr_lo]  = cmderr_q;
        case (addr_q)
            addr_data0:      rdata = data0_q;
            addr_data1:      rdata = data1_q;
            addr_dmcontrol:  rdata = dmctl_q;
            addr_dmstatus:   rdata = status_word;
            addr_abstractcs: rdata = acs_word;
            default:         rdata = '0; // command and unmapped
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q <= dm_idle;
            addr_q  <= '0;
            op_q    <= dmi_op_nop;
        end else begin
            case (state_q)
                dm_idle: begin
                    if (req_valid_i) begin
                        addr_q  <= req_addr_i;
                        op_q    <= req_op_i;
                        state_q <= start_access ? dm_access : dm_resp;
                    end
                end
                dm_access: state_q <= dm_resp;
                default: begin
                    if (resp_ready_i) begin
                        state_q <= dm_idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            dmctl_q     <= '0;
            data0_q     <= '0;
            data1_q     <= '0;
            cmderr_q    <= cmderr_none;
            cmd_write_q <= 1'b0;
            regno_q     <= '0;
        end else begin
            if (wr_acc && req_addr_i == addr_data0) data0_q <= req_data_i;
            if (wr_acc && req_addr_i == addr_data1) data1_q <= req_data_i;
            if (dmc_wr) dmctl_q <= dmctl_wdata;
            if (wr_acc && req_addr_i == addr_abstractcs) begin
                cmderr_q <= cmderr_q & ~req_data_i[acs_cmderr_hi:acs_cmderr_lo]; // w1c
            end
            if (cmd_wr && cmderr_q == cmderr_none) begin
                if (!sel_halted_i) begin
                    cmderr_q <= cmderr_halt_resume;
                end else if (!cmd_ok) begin
                    cmderr_q <= cmderr_notsup;
                end
            end
            if (start_access) begin
                cmd_write_q <= req_data_i[cmd_write];
                regno_q     <= req_data_i[$bits(regno_t)-1:0];
            end
            if (state_q == dm_access && !cmd_write_q) begin
                data0_q <= rf_rdata_i;
            end
        end
    end

    a_ready_resp_excl: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !(resp_valid_o && req_ready_o))
        else $error("request accepted while a response is pending");

    a_ctl_wr_onehot: assert property (@(posedge clk_i) disable iff (!rstn_i)
        $onehot0(ctl_wr_o))
        else $error("dmcontrol write reached more than one hart");

endmodule

/* verilog/dm_hart_ctl.sv */
// one hart; halt is a level, resume waits for the hart's own acknowledge
`timescale 1ns/1ps

module dm_hart_ctl (
    input  logic                clk_i,
    input  logic                rstn_i,
    input  logic                ctl_wr_i,
    input  dm_pkg::dmi_data_t   ctl_data_i,
    input  logic                resume_ack_i,
    input  logic                halted_i,
    input  logic                running_i,
    input  logic                havereset_i,
    output logic                halt_req_o,
    output logic                resume_req_o,
    output logic                resumeack_o,
    output logic                havereset_o,
    output logic                halted_o,
    output logic                running_o
);
    import dm_pkg::*;

    logic resume_wr;

    // a resume is ignored when the same write asks for a halt
    assign resume_wr = ctl_wr_i && ctl_data_i[dmc_resumereq] && !ctl_data_i[dmc_haltreq];

    assign halted_o  = halted_i;
    assign running_o = running_i;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            halt_req_o   <= 1'b0;
            resume_req_o <= 1'b0;
            resumeack_o  <= 1'b0;
            havereset_o  <= 1'b0;
        end else begin
            if (ctl_wr_i) halt_req_o <= ctl_data_i[dmc_haltreq];
            if (resume_wr) begin
                resume_req_o <= 1'b1;
            end else if (resume_ack_i) begin
                resume_req_o <= 1'b0; // dropped on the edge after the ack
            end
            if (ctl_wr_i && ctl_data_i[dmc_resumereq]) begin
                resumeack_o <= 1'b0;
            end else if (resume_ack_i) begin
                resumeack_o <= 1'b1;
            end
            if (ctl_wr_i && ctl_data_i[dmc_ackhavereset]) begin
                havereset_o <= 1'b0;
            end else if (havereset_i) begin
                havereset_o <= 1'b1;
            end
        end
    end

    a_no_resume_in_halt: assert property (@(posedge clk_i) disable iff (!rstn_i)
        $rose(resume_req_o) |-> !halt_req_o)
        else $error("resume request raised while halt is requested");

endmodule

/* verilog/dm_hart_select.sv */
// a hartsel at or above num_harts reads as nonexistent and reaches no hart
`timescale 1ns/1ps

module dm_hart_select (
    input  dm_pkg::hartsel_t    hartsel_i,
    input  dm_pkg::hart_vec_t   halted_i,
    input  dm_pkg::hart_vec_t   running_i,
    input  dm_pkg::hart_vec_t   resumeack_i,
    input  dm_pkg::hart_vec_t   havereset_i,
    output logic                sel_halted_o,
    output logic                sel_running_o,
    output logic                sel_resumeack_o,
    output logic                sel_havereset_o,
    output logic                sel_nonexistent_o,
    input  logic                rf_we_i,
    input  dm_pkg::regno_t      rf_addr_i,
    input  dm_pkg::dmi_data_t   rf_wdata_i,
    output dm_pkg::dmi_data_t   rf_rdata_o,
    output dm_pkg::hart_vec_t   rf_we_o,
    output dm_pkg::regno_t      rf_addr_o [dm_pkg::num_harts],
    output dm_pkg::dmi_data_t   rf_wdata_o [dm_pkg::num_harts],
    input  dm_pkg::dmi_data_t   rf_rdata_i [dm_pkg::num_harts]
);
    import dm_pkg::*;

    assign sel_nonexistent_o = (hartsel_i >= num_harts);

    always_comb begin
        sel_halted_o    = 1'b0;
        sel_running_o   = 1'b0;
        sel_resumeack_o = 1'b0;
        sel_havereset_o = 1'b0;
        rf_rdata_o      = '0;
        for (int h = 0; h < num_harts; h++) begin
            if (hartsel_i == hartsel_t'(h)) begin
                sel_halted_o    = halted_i[h];
                sel_running_o   = running_i[h];
                sel_resumeack_o = resumeack_i[h];
                sel_havereset_o = havereset_i[h];
                rf_rdata_o      = rf_rdata_i[h];
                rf_we_o[h]      = rf_we_i;
                rf_addr_o[h]    = rf_addr_i;
                rf_wdata_o[h]   = rf_wdata_i;
            end else begin
                rf_we_o[h]      = 1'b0; // unselected harts stay quiet
                rf_addr_o[h]    = '0;
                rf_wdata_o[h]   = '0;
            end
        end
    end

endmodule

/* verilog/dm_pkg.sv */
// four harts, 32-bit GPR access only; hartselhi is ignored and no program buffer exists
package dm_pkg;

    localparam int unsigned num_harts = 4;
    localparam int unsigned xlen      = 32;

    typedef logic [6:0]           dmi_addr_t;
    typedef logic [xlen-1:0]      dmi_data_t;
    typedef logic [1:0]           dmi_op_t;
    typedef logic [19:0]          hartsel_t;
    typedef logic [num_harts-1:0] hart_vec_t;
    typedef logic [4:0]           regno_t;
    typedef logic [2:0]           cmderr_t;

    localparam dmi_op_t dmi_op_nop  = 2'd0;
    localparam dmi_op_t dmi_op_rd   = 2'd1;
    localparam dmi_op_t dmi_op_wr   = 2'd2;
    localparam dmi_op_t dmi_resp_ok = 2'd0;

    localparam dmi_addr_t addr_data0      = 7'h04;
    localparam dmi_addr_t addr_data1      = 7'h05;
    localparam dmi_addr_t addr_dmcontrol  = 7'h10;
    localparam dmi_addr_t addr_dmstatus   = 7'h11;
    localparam dmi_addr_t addr_abstractcs = 7'h16;
    localparam dmi_addr_t addr_command    = 7'h17;

    localparam cmderr_t cmderr_none        = 3'd0;
    localparam cmderr_t cmderr_notsup      = 3'd2;
    localparam cmderr_t cmderr_halt_resume = 3'd4;

    // dmcontrol
    localparam int unsigned dmc_dmactive     = 0;
    localparam int unsigned dmc_hartsello_lo = 16;
    localparam int unsigned dmc_hartsello_hi = 25;
    localparam int unsigned dmc_ackhavereset = 28;
    localparam int unsigned dmc_resumereq    = 30;
    localparam int unsigned dmc_haltreq      = 31;

    // dmstatus, each any bit has its all bit just above it
    localparam int unsigned dms_version_hi    = 3;
    localparam logic [3:0]  dms_version       = 4'd3;
    localparam int unsigned dms_authenticated = 7;
    localparam int unsigned dms_halted        = 8;
    localparam int unsigned dms_running       = 10;
    localparam int unsigned dms_nonexistent   = 14;
    localparam int unsigned dms_resumeack     = 16;
    localparam int unsigned dms_havereset     = 18;

    // abstractcs
    localparam int unsigned acs_datacount_hi = 3;
    localparam logic [3:0]  acs_datacount    = 4'd2;
    localparam int unsigned acs_cmderr_lo    = 8;
    localparam int unsigned acs_cmderr_hi    = 10;

    // command, access register only
    localparam int unsigned cmd_cmdtype_lo     = 24;
    localparam int unsigned cmd_cmdtype_hi     = 31;
    localparam int unsigned cmd_aarsize_lo     = 20;
    localparam int unsigned cmd_aarsize_hi     = 22;
    localparam int unsigned cmd_transfer       = 17;
    localparam int unsigned cmd_write          = 16;
    localparam int unsigned cmd_regno_hi       = 15;
    localparam logic [7:0]  cmdtype_access_reg = 8'd0;
    localparam logic [2:0]  aarsize_32         = 3'd2;
    localparam logic [15:0] regno_gpr_first    = 16'h1000;
    localparam logic [15:0] regno_gpr_last     = 16'h101f;

    typedef enum logic [1:0] {
        dm_idle,
        dm_resp,
        dm_access
    } dm_state_t;

endpackage

/* verilog/dm_top.sv */
// debug module for num_harts harts; register access needs the selected hart halted
`timescale 1ns/1ps

module dm_top (
    input  logic                clk_i,
    input  logic                rstn_i,
    input  logic                req_valid_i,
    output logic                req_ready_o,
    input  dm_pkg::dmi_addr_t   req_addr_i,
    input  dm_pkg::dmi_data_t   req_data_i,
    input  dm_pkg::dmi_op_t     req_op_i,
    output logic                resp_valid_o,
    input  logic                resp_ready_i,
    output dm_pkg::dmi_data_t   resp_data_o,
    output dm_pkg::dmi_op_t     resp_op_o,
    output dm_pkg::hart_vec_t   halt_req_o,
    output dm_pkg::hart_vec_t   resume_req_o,
    input  dm_pkg::hart_vec_t   resume_ack_i,
    input  dm_pkg::hart_vec_t   halted_i,
    input  dm_pkg::hart_vec_t   running_i,
    input  dm_pkg::hart_vec_t   havereset_i,
    output dm_pkg::hart_vec_t   rf_we_o,
    output dm_pkg::regno_t      rf_addr_o [dm_pkg::num_harts],
    output dm_pkg::dmi_data_t   rf_wdata_o [dm_pkg::num_harts],
    input  dm_pkg::dmi_data_t   rf_rdata_i [dm_pkg::num_harts]
);
    import dm_pkg::*;

    hart_vec_t  ctl_wr;
    dmi_data_t  ctl_data;
    hartsel_t   hartsel;
    hart_vec_t  hart_halted;
    hart_vec_t  hart_running;
    hart_vec_t  hart_resumeack;
    hart_vec_t  hart_havereset;
    logic       sel_halted;
    logic       sel_running;
    logic       sel_resumeack;
    logic       sel_havereset;
    logic       sel_nonexistent;
    logic       rf_we;
    regno_t     rf_addr;
    dmi_data_t  rf_wdata;
    dmi_data_t  rf_rdata;

    dm_dmi_regs i_dmi_regs (
        .clk_i, .rstn_i,
        .req_valid_i, .req_ready_o, .req_addr_i, .req_data_i, .req_op_i,
        .resp_valid_o, .resp_ready_i, .resp_data_o, .resp_op_o,
        .ctl_wr_o          (ctl_wr),
        .ctl_data_o        (ctl_data),
        .hartsel_o         (hartsel),
        .sel_halted_i      (sel_halted),
        .sel_running_i     (sel_running),
        .sel_resumeack_i   (sel_resumeack),
        .sel_havereset_i   (sel_havereset),
        .sel_nonexistent_i (sel_nonexistent),
        .rf_we_o           (rf_we),
        .rf_addr_o         (rf_addr),
        .rf_wdata_o        (rf_wdata),
        .rf_rdata_i        (rf_rdata)
    );

    for (genvar h = 0; h < num_harts; h++) begin : g_hart
        dm_hart_ctl i_hart_ctl (
            .clk_i, .rstn_i,
            .ctl_wr_i     (ctl_wr[h]),
            .ctl_data_i   (ctl_data),
            .resume_ack_i (resume_ack_i[h]),
            .halted_i     (halted_i[h]),
            .running_i    (running_i[h]),
            .havereset_i  (havereset_i[h]),
            .halt_req_o   (halt_req_o[h]),
            .resume_req_o (resume_req_o[h]),
            .resumeack_o  (hart_resumeack[h]),
            .havereset_o  (hart_havereset[h]),
            .halted_o     (hart_halted[h]),
            .running_o    (hart_running[h])
        );
    end

    dm_hart_select i_hart_select (
        .hartsel_i         (hartsel),
        .halted_i          (hart_halted),
        .running_i         (hart_running),
        .resumeack_i       (hart_resumeack),
        .havereset_i       (hart_havereset),
        .sel_halted_o      (sel_halted),
        .sel_running_o     (sel_running),
        .sel_resumeack_o   (sel_resumeack),
        .sel_havereset_o   (sel_havereset),
        .sel_nonexistent_o (sel_nonexistent),
        .rf_we_i           (rf_we),
        .rf_addr_i         (rf_addr),
        .rf_wdata_i        (rf_wdata),
        .rf_rdata_o        (rf_rdata),
        .rf_we_o, .rf_addr_o, .rf_wdata_o, .rf_rdata_i
    );

endmodule
